//--- logic/cpuPkg.sv
package cpuPkg;

   // Machine sizes
   localparam int dataWidth    = 16;
   localparam int regAddrWidth = 3;
   localparam int imemDepth    = 256;
   localparam int dmemDepth    = 256;

   // Opcodes, the top five bits of every word
   localparam logic [4:0] opHalt = 5'b00000;
   localparam logic [4:0] opNop  = 5'b00001;
   localparam logic [4:0] opAddi = 5'b01000;
   localparam logic [4:0] opBeqz = 5'b01100;
   localparam logic [4:0] opSt   = 5'b10000;
   localparam logic [4:0] opLd   = 5'b10001;
   localparam logic [4:0] opAlu  = 5'b11011;

   // Function codes of opAlu
   localparam logic [1:0] fnAdd = 2'b00;
   localparam logic [1:0] fnSub = 2'b01;
   localparam logic [1:0] fnXor = 2'b10;
   localparam logic [1:0] fnAnd = 2'b11;

   // Register format: rd = rs op rt
   typedef struct packed {
      logic [4:0] opcode;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [2:0] rd;
      logic [1:0] funct;
   } instrR;

   // Immediate format, also used by ld, st and beqz
   // For st the rd slot names the data register
   typedef struct packed {
      logic [4:0]        opcode;
      logic [2:0]        rs;
      logic [2:0]        rd;
      logic signed [4:0] imm;
   } instrI;

   typedef union packed {
      instrR r;
      instrI i;
   } instrT;

   localparam logic [dataWidth-1:0] nopWord = {opNop, 11'b0};

endpackage

//--- logic/fetch.sv
`timescale 1ns/1ps
`default_nettype none
module fetch (
   input  logic                                 clk,
   input  logic                                 rstN,
   input  logic                                 imemWe,
   input  logic [$clog2(cpuPkg::imemDepth)-1:0] imemAddr,
   input  logic [cpuPkg::dataWidth-1:0]         imemWdata,
   input  logic                                 branchTaken,
   input  logic [cpuPkg::dataWidth-1:0]         branchTarget,
   input  logic                                 halted,
   output logic [cpuPkg::dataWidth-1:0]         instrF2D,
   output logic [cpuPkg::dataWidth-1:0]         pcIncF2D
);
   import cpuPkg::*;

   logic [dataWidth-1:0] imem [imemDepth];
   logic [dataWidth-1:0] pc;
   logic [dataWidth-1:0] pcInc;

   assign pcInc = pc + 1'b1;

   // Program is loaded only while the core is held in reset
   always_ff @(posedge clk) begin
      if (!rstN && imemWe) begin
         imem[imemAddr] <= imemWdata;
      end
   end

   // Halt wins over a late branch from the shadow of the halt
   always_ff @(posedge clk) begin
      if (!rstN) begin
         pc       <= '0;
         instrF2D <= nopWord;
      end else if (halted) begin
         instrF2D <= nopWord;
      end else if (branchTaken) begin
         pc       <= branchTarget;
         instrF2D <= nopWord;
      end else begin
         pc       <= pcInc;
         instrF2D <= imem[pc[$clog2(imemDepth)-1:0]];
      end
   end

   always_ff @(posedge clk) begin
      pcIncF2D <= pcInc;
   end

endmodule
`default_nettype wire

//--- logic/regFile.sv
`timescale 1ns/1ps
`default_nettype none
module regFile (
   input  logic                           clk,
   input  logic                           rstN,
   input  logic [cpuPkg::regAddrWidth-1:0] rdAddr1,
   input  logic [cpuPkg::regAddrWidth-1:0] rdAddr2,
   input  logic                           wrEn,
   input  logic [cpuPkg::regAddrWidth-1:0] wrAddr,
   input  logic [cpuPkg::dataWidth-1:0]    wrData,
   output logic [cpuPkg::dataWidth-1:0]    rdData1,
   output logic [cpuPkg::dataWidth-1:0]    rdData2
);
   import cpuPkg::*;

   logic [dataWidth-1:0] regs [2**regAddrWidth];

   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int k = 0; k < 2**regAddrWidth; k++) begin
            regs[k] <= '0;
         end
      end else if (wrEn) begin
         regs[wrAddr] <= wrData;
      end
   end

   // Writeback in the same cycle is seen by the reader
   assign rdData1 = (wrEn && wrAddr == rdAddr1) ? wrData : regs[rdAddr1];
   assign rdData2 = (wrEn && wrAddr == rdAddr2) ? wrData : regs[rdAddr2];

endmodule
`default_nettype wire

//--- logic/decode.sv
`timescale 1ns/1ps
`default_nettype none
module decode (
   input  logic                            clk,
   input  logic                            rstN,
   input  logic [cpuPkg::dataWidth-1:0]    instrF2D,
   input  logic [cpuPkg::dataWidth-1:0]    pcIncF2D,
   input  logic                            flush,
   input  logic                            wbEn,
   input  logic [cpuPkg::regAddrWidth-1:0] wbReg,
   input  logic [cpuPkg::dataWidth-1:0]    wbData,
   output logic [cpuPkg::dataWidth-1:0]    instrD2X,
   output logic [cpuPkg::dataWidth-1:0]    rs1D2X,
   output logic [cpuPkg::dataWidth-1:0]    rs2D2X,
   output logic [cpuPkg::dataWidth-1:0]    immD2X,
   output logic [cpuPkg::dataWidth-1:0]    pcIncD2X,
   output logic                            err
);
   import cpuPkg::*;

   instrT                instr;
   logic                 legal;
   logic [dataWidth-1:0] rdData1;
   logic [dataWidth-1:0] rdData2;
   logic [dataWidth-1:0] immExt;

   assign instr = instrF2D;

   always_comb begin
      case (instr.r.opcode)
         opAlu, opAddi, opLd, opSt, opBeqz, opHalt, opNop: legal = 1'b1;
         default: legal = 1'b0;
      endcase
   end

   // Store data sits in the I-format rd slot, which lines up with rt
   regFile iRegFile (
      .clk     (clk),
      .rstN    (rstN),
      .rdAddr1 (instr.r.rs),
      .rdAddr2 (instr.r.rt),
      .wrEn    (wbEn),
      .wrAddr  (wbReg),
      .wrData  (wbData),
      .rdData1 (rdData1),
      .rdData2 (rdData2)
   );

   assign immExt = {{(dataWidth - 5){instr.i.imm[4]}}, instr.i.imm};

   always_ff @(posedge clk) begin
      if (!rstN) begin
         instrD2X <= nopWord;
         err      <= 1'b0;
      end else begin
         // A bad word in a branch shadow never executes, so it is not flagged
         if (!legal && !flush) begin
            err <= 1'b1;
         end
         instrD2X <= (flush || !legal) ? nopWord : instrF2D;
      end
   end

   always_ff @(posedge clk) begin
      rs1D2X   <= rdData1;
      rs2D2X   <= rdData2;
      immD2X   <= immExt;
      pcIncD2X <= pcIncF2D;
   end

endmodule
`default_nettype wire

//--- logic/execute.sv
`timescale 1ns/1ps
`default_nettype none
module execute (
   input  logic                         clk,
   input  logic                         rstN,
   input  logic [cpuPkg::dataWidth-1:0] instrD2X,
   input  logic [cpuPkg::dataWidth-1:0] rs1D2X,
   input  logic [cpuPkg::dataWidth-1:0] rs2D2X,
   input  logic [cpuPkg::dataWidth-1:0] immD2X,
   input  logic [cpuPkg::dataWidth-1:0] pcIncD2X,
   output logic [cpuPkg::dataWidth-1:0] instrX2M,
   output logic [cpuPkg::dataWidth-1:0] aluX2M,
   output logic [cpuPkg::dataWidth-1:0] storeX2M,
   output logic                         branchTaken,
   output logic [cpuPkg::dataWidth-1:0] branchTarget,
   output logic                         flush
);
   import cpuPkg::*;

   instrT                instr;
   logic [dataWidth-1:0] aluOut;

   assign instr = instrD2X;

   always_comb begin
      if (instr.r.opcode == opAlu) begin
         case (instr.r.funct)
            fnAdd:   aluOut = rs1D2X + rs2D2X;
            fnSub:   aluOut = rs1D2X - rs2D2X;   // rs minus rt
            fnAnd:   aluOut = rs1D2X & rs2D2X;
            default: aluOut = rs1D2X ^ rs2D2X;
         endcase
      end else begin
         // addi result, or effective address for ld and st
         aluOut = rs1D2X + immD2X;
      end
   end

   // Branch resolves here and kills the two younger words
   assign branchTaken  = (instr.i.opcode == opBeqz) && (rs1D2X == '0);
   assign branchTarget = pcIncD2X + immD2X;
   assign flush        = branchTaken;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         instrX2M <= nopWord;
      end else begin
         instrX2M <= instrD2X;
      end
   end

   always_ff @(posedge clk) begin
      aluX2M   <= aluOut;
      storeX2M <= rs2D2X;
   end

endmodule
`default_nettype wire

//--- logic/memory.sv
`timescale 1ns/1ps
`default_nettype none
module memory (
   input  logic                            clk,
   input  logic                            rstN,
   input  logic [cpuPkg::dataWidth-1:0]    instrX2M,
   input  logic [cpuPkg::dataWidth-1:0]    aluX2M,
   input  logic [cpuPkg::dataWidth-1:0]    storeX2M,
   output logic                            wbEn,
   output logic [cpuPkg::regAddrWidth-1:0] wbReg,
   output logic [cpuPkg::dataWidth-1:0]    wbData,
   output logic                            halted
);
   import cpuPkg::*;

   logic [dataWidth-1:0] dmem [dmemDepth];
   logic [dataWidth-1:0] loadData;
   instrT                instr;
   instrT                wbInstr;
   logic [dataWidth-1:0] wbResult;

   assign instr    = instrX2M;
   assign loadData = dmem[aluX2M[$clog2(dmemDepth)-1:0]];

   // Words behind a halt must not touch memory
   always_ff @(posedge clk) begin
      if (rstN && !halted && instr.i.opcode == opSt) begin
         dmem[aluX2M[$clog2(dmemDepth)-1:0]] <= storeX2M;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         wbInstr <= nopWord;
         halted  <= 1'b0;
      end else begin
         wbInstr <= halted ? nopWord : instrX2M;
         if (instr.i.opcode == opHalt) begin
            halted <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      wbResult <= (instr.i.opcode == opLd) ? loadData : aluX2M;
   end

   // Writeback decode from the latched word
   assign wbEn   = (wbInstr.r.opcode == opAlu) || (wbInstr.i.opcode == opAddi) ||
                   (wbInstr.i.opcode == opLd);
   assign wbReg  = (wbInstr.r.opcode == opAlu) ? wbInstr.r.rd : wbInstr.i.rd;
   assign wbData = wbResult;

endmodule
`default_nettype wire

//--- logic/proc.sv
`timescale 1ns/1ps
`default_nettype none
module proc (
   input  logic                                 clk,
   input  logic                                 rstN,
   input  logic                                 imemWe,
   input  logic [$clog2(cpuPkg::imemDepth)-1:0] imemAddr,
   input  logic [cpuPkg::dataWidth-1:0]         imemWdata,
   output logic                                 retireValid,
   output logic [cpuPkg::regAddrWidth-1:0]      retireReg,
   output logic [cpuPkg::dataWidth-1:0]         retireData,
   output logic                                 halted,
   output logic                                 err
);
   import cpuPkg::*;

   logic [dataWidth-1:0]    instrF2D, pcIncF2D;
   logic [dataWidth-1:0]    instrD2X, rs1D2X, rs2D2X, immD2X, pcIncD2X;
   logic [dataWidth-1:0]    instrX2M, aluX2M, storeX2M;
   logic [dataWidth-1:0]    branchTarget;
   logic                    branchTaken, flush;
   logic                    wbEn;
   logic [regAddrWidth-1:0] wbReg;
   logic [dataWidth-1:0]    wbData;
   logic                    decodeErr;

   // Only decode can trap today; more sources get ORed in here
   assign err = decodeErr;

   // Every register write is reported on the trace port
   assign retireValid = wbEn;
   assign retireReg   = wbReg;
   assign retireData  = wbData;

   fetch iFetch (
      .clk (clk), .rstN (rstN), .imemWe (imemWe), .imemAddr (imemAddr),
      .imemWdata (imemWdata), .branchTaken (branchTaken), .branchTarget (branchTarget),
      .halted (halted), .instrF2D (instrF2D), .pcIncF2D (pcIncF2D)
   );

   decode iDecode (
      .clk (clk), .rstN (rstN), .instrF2D (instrF2D), .pcIncF2D (pcIncF2D),
      .flush (flush), .wbEn (wbEn), .wbReg (wbReg), .wbData (wbData),
      .instrD2X (instrD2X), .rs1D2X (rs1D2X), .rs2D2X (rs2D2X), .immD2X (immD2X),
      .pcIncD2X (pcIncD2X), .err (decodeErr)
   );

   execute iExecute (
      .clk (clk), .rstN (rstN), .instrD2X (instrD2X), .rs1D2X (rs1D2X),
      .rs2D2X (rs2D2X), .immD2X (immD2X), .pcIncD2X (pcIncD2X),
      .instrX2M (instrX2M), .aluX2M (aluX2M), .storeX2M (storeX2M),
      .branchTaken (branchTaken), .branchTarget (branchTarget), .flush (flush)
   );

   memory iMemory (
      .clk (clk), .rstN (rstN), .instrX2M (instrX2M), .aluX2M (aluX2M),
      .storeX2M (storeX2M), .wbEn (wbEn), .wbReg (wbReg), .wbData (wbData),
      .halted (halted)
   );

endmodule
`default_nettype wire

//--- verif/proc_asserts.sv
`timescale 1ns/1ps
module procAsserts (
   input logic clk,
   input logic rstN,
   input logic retireValid,
   input logic halted,
   input logic err
);
   int assertFailures = 0;

   // Status outputs come out of a reset edge low
   resetQuiet: assert property (@(posedge clk) !rstN |=> !retireValid && !halted && !err)
      else begin
         $error("retireValid, halted or err high after a reset edge");
         assertFailures++;
      end

   haltSticky: assert property (@(posedge clk) disable iff (!rstN) halted |=> halted)
      else begin
         $error("halted fell without a reset");
         assertFailures++;
      end

   errSticky: assert property (@(posedge clk) disable iff (!rstN) err |=> err)
      else begin
         $error("err fell without a reset");
         assertFailures++;
      end

   // Pipeline drains within four cycles of the halt
   quietAfterHalt: assert property (@(posedge clk) disable iff (!rstN)
      halted && $past(halted, 4) |-> !retireValid)
      else begin
         $error("retirement more than four cycles after halted rose");
         assertFailures++;
      end

endmodule

bind proc procAsserts iAsserts (
   .clk (clk), .rstN (rstN), .retireValid (retireValid), .halted (halted), .err (err)
);

//--- verif/procTb.sv
`timescale 1ns/1ps
module procTb;
   import cpuPkg::*;

   localparam int maxCycles = 2000;
   localparam int haltLimit = 300;

   logic        clk;
   logic        rstN;
   logic        imemWe;
   logic [7:0]  imemAddr;
   logic [15:0] imemWdata;
   logic        retireValid;
   logic [2:0]  retireReg;
   logic [15:0] retireData;
   logic        halted;
   logic        err;

   int          seed;
   int          cycleCount;
   int          valueErrors;
   int          otherErrors;
   int          retireIdx;
   logic [15:0] prog [$];
   logic [2:0]  expReg [$];
   logic [15:0] expData [$];
   logic        expErr;

   proc u_proc (
      .clk (clk), .rstN (rstN), .imemWe (imemWe), .imemAddr (imemAddr),
      .imemWdata (imemWdata), .retireValid (retireValid), .retireReg (retireReg),
      .retireData (retireData), .halted (halted), .err (err)
   );

   always #50 clk = ~clk;

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= maxCycles) begin
         $display("Run stopped at the %0d cycle limit before the tests ended", maxCycles);
         $display("TESTS FAILED");
         $finish;
      end
   end

   function automatic logic [15:0] immWord(logic [4:0] op, logic [2:0] rd, logic [2:0] rs,
                                           logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   function automatic logic [15:0] aluWord(logic [1:0] fn, logic [2:0] rd, logic [2:0] rs,
                                           logic [2:0] rt);
      return {opAlu, rs, rt, rd, fn};
   endfunction

   // Three nops keep a later reader clear of this write
   task automatic addSpaced(logic [15:0] word);
      prog.push_back(word);
      repeat (3) prog.push_back(nopWord);
   endtask

   // Sequential ISA model that lists the expected register writes
   task automatic runModel();
      logic [15:0] regs [8];
      logic [15:0] dmem [256];
      logic [15:0] word;
      logic [15:0] imm;
      logic [15:0] addr;
      logic [15:0] res;
      logic [2:0]  dest;
      logic        writes;
      int          pc;
      expReg.delete();
      expData.delete();
      expErr = 1'b0;
      foreach (regs[k]) regs[k] = '0;
      foreach (dmem[k]) dmem[k] = '0;
      pc = 0;
      while (pc >= 0 && pc < prog.size()) begin
         word   = prog[pc];
         imm    = {{11{word[4]}}, word[4:0]};
         addr   = regs[word[10:8]] + imm;
         res    = addr;
         dest   = word[7:5];
         writes = 1'b0;
         pc++;
         if (word[15:11] == opHalt) break;
         case (word[15:11])
            opAlu: begin
               writes = 1'b1;
               dest   = word[4:2];
               case (word[1:0])
                  fnAdd:   res = regs[word[10:8]] + regs[word[7:5]];
                  fnSub:   res = regs[word[10:8]] - regs[word[7:5]];
                  fnAnd:   res = regs[word[10:8]] & regs[word[7:5]];
                  default: res = regs[word[10:8]] ^ regs[word[7:5]];
               endcase
            end
            opAddi: writes = 1'b1;
            opLd: begin
               writes = 1'b1;
               res    = dmem[addr[7:0]];
            end
            opSt:   dmem[addr[7:0]] = regs[word[7:5]];
            opBeqz: if (regs[word[10:8]] == '0) pc = pc + int'($signed(imm));
            opNop:  ;
            default: expErr = 1'b1;
         endcase
         if (writes) begin
            regs[dest] = res;
            expReg.push_back(dest);
            expData.push_back(res);
         end
      end
   endtask

   task automatic checkRetirement(string name);
      if (!retireValid) return;
      if (retireIdx >= expReg.size()) begin
         otherErrors++;
         $display("%s: unexpected retirement of r%0d = %h", name, retireReg, retireData);
      end else begin
         if (retireReg !== expReg[retireIdx]) begin
            valueErrors++;
            $display("CHECK FAILED %s: retirement %0d register expected %0d actual %0d",
                     name, retireIdx, expReg[retireIdx], retireReg);
         end
         if (retireData !== expData[retireIdx]) begin
            valueErrors++;
            $display("CHECK FAILED %s: retirement %0d data expected %h actual %h",
                     name, retireIdx, expData[retireIdx], retireData);
         end
      end
      retireIdx++;
   endtask

   // Reload under reset, run to halt, then watch the drained pipeline
   task automatic runProgram(string name);
      int waited;
      runModel();
      @(negedge clk);
      rstN = 1'b0;
      for (int idx = 0; idx < prog.size() + 4; idx++) begin
         imemWe    = 1'b1;
         imemAddr  = idx[7:0];
         imemWdata = (idx < prog.size()) ? prog[idx] : nopWord;
         @(negedge clk);
      end
      imemWe    = 1'b0;
      rstN      = 1'b1;
      retireIdx = 0;
      waited    = 0;
      while (!halted && waited < haltLimit) begin
         @(negedge clk);
         waited++;
         checkRetirement(name);
      end
      if (!halted) begin
         otherErrors++;
         $display("%s: halted did not rise within %0d cycles", name, haltLimit);
      end
      repeat (8) begin
         @(negedge clk);
         checkRetirement(name);
      end
      if (retireIdx != expReg.size()) begin
         otherErrors++;
         $display("%s: saw %0d of %0d expected retirements", name, retireIdx, expReg.size());
      end
      if (err !== expErr) begin
         valueErrors++;
         $display("CHECK FAILED %s: err expected %b actual %b", name, expErr, err);
      end
   endtask

   task automatic testAluOps();
      int rnd;
      prog.delete();
      rnd = $random(seed);
      addSpaced(immWord(opAddi, 3'd1, 3'd0, rnd[4:0]));
      rnd = $random(seed);
      addSpaced(immWord(opAddi, 3'd2, 3'd0, rnd[4:0]));
      // Double r1 and negate r2 so the upper bits take part
      addSpaced(aluWord(fnAdd, 3'd1, 3'd1, 3'd1));
      addSpaced(aluWord(fnSub, 3'd2, 3'd0, 3'd2));
      addSpaced(aluWord(fnAdd, 3'd3, 3'd1, 3'd2));
      addSpaced(aluWord(fnSub, 3'd4, 3'd1, 3'd2));
      addSpaced(aluWord(fnAnd, 3'd5, 3'd1, 3'd2));
      addSpaced(aluWord(fnXor, 3'd6, 3'd1, 3'd2));
      prog.push_back({opHalt, 11'd0});
      runProgram("aluOps");
   endtask

   task automatic testAddiSign();
      int rnd;
      prog.delete();
      rnd = $random(seed);
      addSpaced(immWord(opAddi, 3'd1, 3'd0, 5'h10));
      addSpaced(immWord(opAddi, 3'd2, 3'd0, 5'h0f));
      addSpaced(immWord(opAddi, 3'd3, 3'd1, 5'h1f));
      addSpaced(immWord(opAddi, 3'd4, 3'd2, 5'h11));
      addSpaced(immWord(opAddi, 3'd5, 3'd3, rnd[4:0]));
      prog.push_back({opHalt, 11'd0});
      runProgram("addiSign");
   endtask

   task automatic testStoreLoad();
      int rnd;
      prog.delete();
      rnd = $random(seed);
      addSpaced(immWord(opAddi, 3'd1, 3'd0, 5'd13));
      addSpaced(immWord(opAddi, 3'd2, 3'd0, 5'd6));
      addSpaced(immWord(opAddi, 3'd3, 3'd0, rnd[4:0]));
      prog.push_back(immWord(opSt, 3'd1, 3'd2, 5'd3));
      addSpaced(immWord(opLd, 3'd4, 3'd2, 5'd3));
      prog.push_back(immWord(opSt, 3'd3, 3'd2, 5'h1e));
      addSpaced(immWord(opLd, 3'd5, 3'd2, 5'h1e));
      prog.push_back({opHalt, 11'd0});
      runProgram("storeLoad");
   endtask

   task automatic testBranch();
      prog.delete();
      addSpaced(immWord(opAddi, 3'd1, 3'd0, 5'd7));
      prog.push_back(immWord(opBeqz, 3'd0, 3'd1, 5'd3));
      addSpaced(immWord(opAddi, 3'd2, 3'd0, 5'd3));
      // Taken, skips the two shadow words and two more
      prog.push_back(immWord(opBeqz, 3'd0, 3'd0, 5'd4));
      prog.push_back(immWord(opAddi, 3'd6, 3'd0, 5'd1));
      prog.push_back(immWord(opAddi, 3'd7, 3'd0, 5'd2));
      prog.push_back(immWord(opAddi, 3'd6, 3'd0, 5'd3));
      prog.push_back(immWord(opAddi, 3'd7, 3'd0, 5'd4));
      addSpaced(immWord(opAddi, 3'd4, 3'd0, 5'd11));
      prog.push_back({opHalt, 11'd0});
      runProgram("branch");
   endtask

   task automatic testIllegal();
      prog.delete();
      addSpaced(immWord(opAddi, 3'd1, 3'd0, 5'd4));
      // Opcode 11111 is undefined, rest of the word looks like a write to r2
      addSpaced({5'b11111, 3'd1, 3'd1, 3'd2, 2'b00});
      addSpaced(immWord(opAddi, 3'd3, 3'd0, 5'h1d));
      addSpaced(aluWord(fnAdd, 3'd4, 3'd1, 3'd3));
      prog.push_back({opHalt, 11'd0});
      runProgram("illegal");
   endtask

   task automatic testHalt();
      prog.delete();
      addSpaced(immWord(opAddi, 3'd1, 3'd0, 5'd5));
      prog.push_back({opHalt, 11'd0});
      prog.push_back(immWord(opAddi, 3'd2, 3'd0, 5'd6));
      prog.push_back(aluWord(fnAdd, 3'd3, 3'd1, 3'd1));
      prog.push_back(immWord(opSt, 3'd1, 3'd0, 5'd2));
      prog.push_back(immWord(opLd, 3'd4, 3'd0, 5'd2));
      prog.push_back(immWord(opAddi, 3'd5, 3'd0, 5'd7));
      runProgram("haltStop");
   endtask

   initial begin
      clk         = 1'b0;
      rstN        = 1'b0;
      imemWe      = 1'b0;
      imemAddr    = '0;
      imemWdata   = '0;
      seed        = 48448;
      cycleCount  = 0;
      valueErrors = 0;
      otherErrors = 0;
      retireIdx   = 0;
      expErr      = 1'b0;
      repeat (3) @(negedge clk);
      testAluOps();
      testAddiSign();
      testStoreLoad();
      testBranch();
      testIllegal();
      testHalt();
      $display("Errors: %0d value, %0d other, %0d assertion", valueErrors, otherErrors,
               u_proc.iAsserts.assertFailures);
      if (valueErrors + otherErrors + u_proc.iAsserts.assertFailures == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- vlog.f
logic/cpuPkg.sv
logic/fetch.sv
logic/regFile.sv
logic/decode.sv
logic/execute.sv
logic/memory.sv
logic/proc.sv
verif/proc_asserts.sv
verif/procTb.sv

//--- run.sh
#!/bin/sh
# Build and run the processor testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module procTb -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/VprocTb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi
echo "$out" | grep -qx "TESTS PASSED" || exit 1
exit 0
